/* src/bp_settings.svh */
// Branch predictor sizes
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// Number of BTB entries, power of two
`define BP_BTB_ENTRIES 32

// Global history length
// The PHT holds 2**BP_GHR_BITS counters
`define BP_GHR_BITS 5

// PC and target width
`define BP_XLEN 32

`endif

/* src/bp_pkg.sv */
// Branch predictor types
`default_nettype none

package bp_pkg;

    // RISC-V major opcodes seen by the predictor
    typedef enum logic [6:0] {
        OP_OTHER  = 7'b0000000,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // 2-bit saturating counter values
    // 00 strong not taken, 11 strong taken
    localparam logic [1:0] CTR_WEAK_NT = 2'b01;
    localparam logic [1:0] CTR_MAX     = 2'b11;

endpackage

`default_nettype wire

/* src/btb_lookup_if.sv */
// BTB lookup result
`default_nettype none

`include "bp_settings.svh"

interface btb_lookup_if;
    logic                hit;
    logic                is_jump;
    logic                is_branch;
    logic [`BP_XLEN-1:0] target;

    modport src (
        output hit,
        output is_jump,
        output is_branch,
        output target
    );

    modport dst (
        input hit,
        input is_jump,
        input is_branch,
        input target
    );
endinterface

`default_nettype wire

/* src/btb.sv */
// Branch target buffer
`default_nettype none

`include "bp_settings.svh"

module btb #(
    parameter  int ENTRIES = `BP_BTB_ENTRIES,
    parameter  int XLEN    = `BP_XLEN,
    localparam int IDX_W   = $clog2(ENTRIES)
) (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire [XLEN-1:0]       pc_i,
    input  wire bp_pkg::opcode_e op_i,
    input  wire                  we_i,
    input  wire [IDX_W-1:0]      waddr_i,
    input  wire [XLEN-1:0]       wdata_i,
    btb_lookup_if.src            lookup_o
);

    // Entry storage
    logic [XLEN-1:0]    tag_q    [ENTRIES];
    logic [XLEN-1:0]    target_q [ENTRIES];
    logic [ENTRIES-1:0] jflag_q;
    logic [ENTRIES-1:0] bflag_q;
    logic [ENTRIES-1:0] valid_q;

    logic [IDX_W-1:0]   rd_idx;
    logic               hit;

    // Fetch tag and hit travel two stages to execute
    logic [XLEN-1:0]    tag_d_q;
    logic [XLEN-1:0]    tag_e_q;
    logic               hit_d_q;
    logic               hit_e_q;

    // Decode opcode travels one stage
    bp_pkg::opcode_e    op_e_q;

    logic               wr_ok;

    assign rd_idx = pc_i[IDX_W+1:2];

    // Full PC compare, so aliasing PCs never hit each other's entry
    assign hit = valid_q[rd_idx] && (tag_q[rd_idx] == pc_i);

    assign lookup_o.hit       = hit;
    assign lookup_o.is_jump   = jflag_q[rd_idx];
    assign lookup_o.is_branch = bflag_q[rd_idx];
    assign lookup_o.target    = target_q[rd_idx];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tag_d_q <= '0;
            tag_e_q <= '0;
            hit_d_q <= 1'b0;
            hit_e_q <= 1'b0;
            op_e_q  <= bp_pkg::OP_OTHER;
        end else begin
            tag_d_q <= pc_i;
            tag_e_q <= tag_d_q;
            hit_d_q <= hit;
            hit_e_q <= hit_d_q;
            op_e_q  <= op_i;
        end
    end

    // Refill only when the instruction missed at fetch,
    // or its slot has since gone invalid
    assign wr_ok = we_i && (!hit_e_q || !valid_q[waddr_i]);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_ok) begin
            valid_q[waddr_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            tag_q[waddr_i]    <= tag_e_q;
            target_q[waddr_i] <= wdata_i;
            jflag_q[waddr_i]  <= (op_e_q == bp_pkg::OP_JAL) || (op_e_q == bp_pkg::OP_JALR);
            bflag_q[waddr_i]  <= (op_e_q == bp_pkg::OP_BRANCH);
        end
    end

    // The selector and the refill path both depend on a clean hit
    a_hit_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(lookup_o.hit)
    );

endmodule

`default_nettype wire

/* src/gshare_pht.sv */
// Gshare pattern history table
`default_nettype none

`include "bp_settings.svh"

module gshare_pht #(
    parameter  int XLEN  = `BP_XLEN,
    parameter  int GHR_W = `BP_GHR_BITS,
    localparam int DEPTH = 1 << GHR_W
) (
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire [XLEN-1:0]   pc_i,
    input  wire              ghr_clear_i,
    input  wire              taken_i,
    input  wire              we_i,
    input  wire              inc_i,
    input  wire [GHR_W-1:0]  waddr_i,
    output logic [GHR_W-1:0] raddr_o,
    output logic             pred_taken_o
);

    logic [GHR_W-1:0] ghr_q;
    logic [1:0]       pht_q [DEPTH];
    logic [GHR_W-1:0] rd_idx;
    logic [1:0]       wr_ctr;

    // Gshare index, word-aligned PC bits folded with history
    assign rd_idx       = pc_i[GHR_W+1:2] ^ ghr_q;
    assign raddr_o      = rd_idx;
    assign pred_taken_o = pht_q[rd_idx][1];

    // Saturating step of the addressed counter
    always_comb begin
        wr_ctr = pht_q[waddr_i];
        if (inc_i && (pht_q[waddr_i] != bp_pkg::CTR_MAX)) begin
            wr_ctr = pht_q[waddr_i] + 2'd1;
        end else if (!inc_i && (pht_q[waddr_i] != 2'b00)) begin
            wr_ctr = pht_q[waddr_i] - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                pht_q[i] <= bp_pkg::CTR_WEAK_NT;
            end
        end else if (we_i) begin
            pht_q[waddr_i] <= wr_ctr;
        end
    end

    // History takes every prediction, not only resolved branches
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (ghr_clear_i) begin
            ghr_q <= '0;
        end else begin
            ghr_q <= {ghr_q[GHR_W-2:0], taken_i};
        end
    end

    // Counter moves by one step at most per update
    a_ctr_step: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        we_i |=> (2'(pht_q[$past(waddr_i)] - $past(pht_q[waddr_i])) != 2'b10)
    );

endmodule

`default_nettype wire

/* src/predict_select.sv */
// Next-PC selection
`default_nettype none

`include "bp_settings.svh"

module predict_select #(
    parameter int XLEN = `BP_XLEN
) (
    input  wire [XLEN-1:0]  pc_i,
    btb_lookup_if.dst       lookup_i,
    input  wire             pht_taken_i,
    output logic [XLEN-1:0] target_o,
    output logic            taken_o
);

    always_comb begin
        // Fall through to the next sequential instruction
        target_o = pc_i + XLEN'(4);
        taken_o  = 1'b0;
        if (lookup_i.hit && lookup_i.is_jump) begin
            // Jumps are always taken
            target_o = lookup_i.target;
            taken_o  = 1'b1;
        end else if (lookup_i.hit && lookup_i.is_branch) begin
            target_o = lookup_i.target;
            taken_o  = pht_taken_i;
        end
    end

    // Refill decodes a single opcode, so one kind per entry
    always_comb begin
        if (lookup_i.hit === 1'b1) begin
            a_one_kind: assert final (!(lookup_i.is_jump && lookup_i.is_branch));
        end
    end

endmodule

`default_nettype wire

/* src/branch_predictor.sv */
// Branch predictor top
`default_nettype none

`include "bp_settings.svh"

module branch_predictor (
    input  wire                               clk,
    input  wire                               rst_n_i,
    input  wire [`BP_XLEN-1:0]                pc_i,
    input  wire bp_pkg::opcode_e              op_i,
    input  wire                               btb_we_i,
    input  wire [$clog2(`BP_BTB_ENTRIES)-1:0] btb_waddr_i,
    input  wire [`BP_XLEN-1:0]                btb_wdata_i,
    input  wire                               pht_we_i,
    input  wire                               pht_inc_i,
    input  wire [`BP_GHR_BITS-1:0]            pht_waddr_i,
    input  wire                               ghr_clear_i,
    output wire [`BP_XLEN-1:0]                target_o,
    output wire                               taken_o,
    output wire [`BP_GHR_BITS-1:0]            pht_raddr_o
);

    btb_lookup_if lookup ();

    wire pht_taken;

    btb u_btb (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .pc_i     (pc_i),
        .op_i     (op_i),
        .we_i     (btb_we_i),
        .waddr_i  (btb_waddr_i),
        .wdata_i  (btb_wdata_i),
        .lookup_o (lookup)
    );

    // Final taken feeds back into the history register
    gshare_pht u_pht (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc_i),
        .ghr_clear_i  (ghr_clear_i),
        .taken_i      (taken_o),
        .we_i         (pht_we_i),
        .inc_i        (pht_inc_i),
        .waddr_i      (pht_waddr_i),
        .raddr_o      (pht_raddr_o),
        .pred_taken_o (pht_taken)
    );

    predict_select u_sel (
        .pc_i        (pc_i),
        .lookup_i    (lookup),
        .pht_taken_i (pht_taken),
        .target_o    (target_o),
        .taken_o     (taken_o)
    );

endmodule

`default_nettype wire

/* tests/bp_checker.sv */
// Branch predictor reference checker
`default_nettype none

`include "bp_settings.svh"

module bp_checker #(
    parameter  int PERIOD  = 100,
    localparam int XLEN    = `BP_XLEN,
    localparam int ENTRIES = `BP_BTB_ENTRIES,
    localparam int IDX_W   = $clog2(`BP_BTB_ENTRIES),
    localparam int GHR_W   = `BP_GHR_BITS
) (
    input wire                  clk,
    input wire                  rst_n_i,
    input wire [XLEN-1:0]       pc_i,
    input wire bp_pkg::opcode_e op_i,
    input wire                  btb_we_i,
    input wire [IDX_W-1:0]      btb_waddr_i,
    input wire [XLEN-1:0]       btb_wdata_i,
    input wire                  pht_we_i,
    input wire                  pht_inc_i,
    input wire [GHR_W-1:0]      pht_waddr_i,
    input wire                  ghr_clear_i,
    input wire [XLEN-1:0]       target_o,
    input wire                  taken_o,
    input wire [GHR_W-1:0]      pht_raddr_o,
    input int                   phase_i
);

    // Model state
    logic [XLEN-1:0]  m_tag    [ENTRIES];
    logic [XLEN-1:0]  m_target [ENTRIES];
    logic             m_valid  [ENTRIES];
    logic             m_jump   [ENTRIES];
    logic             m_branch [ENTRIES];
    logic [1:0]       m_ctr    [1 << GHR_W];
    logic [GHR_W-1:0] m_ghr;

    // Pipeline delays of the refill tag, hit flag and opcode
    logic [XLEN-1:0]  m_tag_d1;
    logic [XLEN-1:0]  m_tag_d2;
    logic             m_hit_d1;
    logic             m_hit_d2;
    bp_pkg::opcode_e  m_op_d1;

    int check_count   = 0;
    int target_errors = 0;
    int taken_errors  = 0;
    int raddr_errors  = 0;
    int taken_seen    = 0;
    int branch_hits   = 0;

    function automatic string phase_name(input int p);
        case (p)
            1:       return "reset_state";
            2:       return "btb_refill";
            3:       return "branch_predict";
            4:       return "counter_saturation";
            5:       return "global_history";
            6:       return "random_mix";
            default: return "reset";
        endcase
    endfunction

    function automatic logic [IDX_W-1:0] btb_index(input logic [XLEN-1:0] pc);
        return pc[IDX_W+1:2];
    endfunction

    function automatic logic model_hit(input logic [XLEN-1:0] pc);
        return m_valid[btb_index(pc)] && (m_tag[btb_index(pc)] == pc);
    endfunction

    function automatic logic [GHR_W-1:0] model_raddr(input logic [XLEN-1:0] pc);
        return pc[GHR_W+1:2] ^ m_ghr;
    endfunction

    function automatic logic model_taken(input logic [XLEN-1:0] pc);
        if (!model_hit(pc)) begin
            return 1'b0;
        end
        if (m_jump[btb_index(pc)]) begin
            return 1'b1;
        end
        if (m_branch[btb_index(pc)]) begin
            return m_ctr[model_raddr(pc)][1];
        end
        return 1'b0;
    endfunction

    function automatic logic [XLEN-1:0] model_target(input logic [XLEN-1:0] pc);
        if (model_hit(pc) && (m_jump[btb_index(pc)] || m_branch[btb_index(pc)])) begin
            return m_target[btb_index(pc)];
        end
        return pc + XLEN'(4);
    endfunction

    task automatic reset_model();
        for (int i = 0; i < ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < (1 << GHR_W); i++) begin
            m_ctr[i] = bp_pkg::CTR_WEAK_NT;
        end
        m_ghr    = '0;
        m_tag_d1 = '0;
        m_tag_d2 = '0;
        m_hit_d1 = 1'b0;
        m_hit_d2 = 1'b0;
        m_op_d1  = bp_pkg::OP_OTHER;
    endtask

    task automatic update_model();
        logic             now_hit;
        logic             now_taken;
        logic [IDX_W-1:0] w;
        now_hit   = model_hit(pc_i);
        now_taken = model_taken(pc_i);
        w         = btb_waddr_i;
        // Refill is judged on the lookup made two cycles earlier
        if (btb_we_i && (!m_hit_d2 || !m_valid[w])) begin
            m_valid[w]  = 1'b1;
            m_tag[w]    = m_tag_d2;
            m_target[w] = btb_wdata_i;
            m_jump[w]   = (m_op_d1 == bp_pkg::OP_JAL) || (m_op_d1 == bp_pkg::OP_JALR);
            m_branch[w] = (m_op_d1 == bp_pkg::OP_BRANCH);
        end
        if (pht_we_i && pht_inc_i && (m_ctr[pht_waddr_i] != bp_pkg::CTR_MAX)) begin
            m_ctr[pht_waddr_i] = m_ctr[pht_waddr_i] + 2'd1;
        end else if (pht_we_i && !pht_inc_i && (m_ctr[pht_waddr_i] != 2'b00)) begin
            m_ctr[pht_waddr_i] = m_ctr[pht_waddr_i] - 2'd1;
        end
        m_ghr    = ghr_clear_i ? '0 : {m_ghr[GHR_W-2:0], now_taken};
        m_tag_d2 = m_tag_d1;
        m_tag_d1 = pc_i;
        m_hit_d2 = m_hit_d1;
        m_hit_d1 = now_hit;
        m_op_d1  = op_i;
    endtask

    task automatic compare_outputs();
        logic [XLEN-1:0]  exp_target;
        logic             exp_taken;
        logic [GHR_W-1:0] exp_raddr;
        exp_target = model_target(pc_i);
        exp_taken  = model_taken(pc_i);
        exp_raddr  = model_raddr(pc_i);
        check_count++;
        if (target_o !== exp_target) begin
            target_errors++;
            $display("Mismatch in %s at %0t: target_o expected %h, actual %h",
                     phase_name(phase_i), $time, exp_target, target_o);
        end
        if (taken_o !== exp_taken) begin
            taken_errors++;
            $display("Mismatch in %s at %0t: taken_o expected %b, actual %b",
                     phase_name(phase_i), $time, exp_taken, taken_o);
        end
        if (pht_raddr_o !== exp_raddr) begin
            raddr_errors++;
            $display("Mismatch in %s at %0t: pht_raddr_o expected %h, actual %h",
                     phase_name(phase_i), $time, exp_raddr, pht_raddr_o);
        end
        // Coverage of the random phase
        if (phase_i == 6) begin
            if (exp_taken) begin
                taken_seen++;
            end
            if (model_hit(pc_i) && m_branch[btb_index(pc_i)]) begin
                branch_hits++;
            end
        end
    endtask

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reset_model();
        end else begin
            update_model();
        end
    end

    // Outputs sampled a quarter period after the falling-edge input change
    always @(negedge clk) begin
        #(PERIOD / 4);
        compare_outputs();
    end

endmodule

`default_nettype wire

/* tests/tb_branch_predictor.sv */
// Branch predictor testbench
`default_nettype none

`include "bp_settings.svh"

module tb_branch_predictor;

    localparam int PERIOD          = 100;
    localparam int XLEN            = `BP_XLEN;
    localparam int IDX_W           = $clog2(`BP_BTB_ENTRIES);
    localparam int GHR_W           = `BP_GHR_BITS;
    localparam int RESET_CYCLES    = 3;
    // Directed phases take about fifty cycles
    localparam int DIRECTED_CYCLES = 80;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TIME_LIMIT      =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 20) * PERIOD;

    localparam logic [XLEN-1:0] FILL_PC = 32'h0000_003c;
    localparam logic [XLEN-1:0] BR_PC   = 32'h0000_0104;

    logic                clk = 1'b0;
    logic                rst_n_i;
    logic [XLEN-1:0]     pc_i;
    bp_pkg::opcode_e     op_i;
    logic                btb_we_i;
    logic [IDX_W-1:0]    btb_waddr_i;
    logic [XLEN-1:0]     btb_wdata_i;
    logic                pht_we_i;
    logic                pht_inc_i;
    logic [GHR_W-1:0]    pht_waddr_i;
    logic                ghr_clear_i;
    wire  [XLEN-1:0]     target_o;
    wire                 taken_o;
    wire  [GHR_W-1:0]    pht_raddr_o;

    int phase        = 0;
    int other_errors = 0;
    int total_errors;

    // 0x180 aliases 0x100 and 0x1104 aliases 0x104 in both tables
    logic [XLEN-1:0] pc_pool [8] = '{
        32'h0000_0100, 32'h0000_0104, 32'h0000_0180, 32'h0000_1104,
        32'h0000_2040, 32'h0000_003c, 32'h0000_007c, 32'h0000_0108
    };
    bp_pkg::opcode_e op_pool [4] = '{
        bp_pkg::OP_OTHER, bp_pkg::OP_BRANCH, bp_pkg::OP_JALR, bp_pkg::OP_JAL
    };

    always #(PERIOD / 2) clk = ~clk;

    branch_predictor DUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pc_i        (pc_i),
        .op_i        (op_i),
        .btb_we_i    (btb_we_i),
        .btb_waddr_i (btb_waddr_i),
        .btb_wdata_i (btb_wdata_i),
        .pht_we_i    (pht_we_i),
        .pht_inc_i   (pht_inc_i),
        .pht_waddr_i (pht_waddr_i),
        .ghr_clear_i (ghr_clear_i),
        .target_o    (target_o),
        .taken_o     (taken_o),
        .pht_raddr_o (pht_raddr_o)
    );

    bp_checker #(.PERIOD(PERIOD)) u_chk (
        .clk         (DUT.clk),
        .rst_n_i     (DUT.rst_n_i),
        .pc_i        (DUT.pc_i),
        .op_i        (DUT.op_i),
        .btb_we_i    (DUT.btb_we_i),
        .btb_waddr_i (DUT.btb_waddr_i),
        .btb_wdata_i (DUT.btb_wdata_i),
        .pht_we_i    (DUT.pht_we_i),
        .pht_inc_i   (DUT.pht_inc_i),
        .pht_waddr_i (DUT.pht_waddr_i),
        .ghr_clear_i (DUT.ghr_clear_i),
        .target_o    (DUT.target_o),
        .taken_o     (DUT.taken_o),
        .pht_raddr_o (DUT.pht_raddr_o),
        .phase_i     (phase)
    );

    task automatic drive(
        input logic [XLEN-1:0]  pc,
        input bp_pkg::opcode_e  op,
        input logic             btb_we,
        input logic [IDX_W-1:0] btb_waddr,
        input logic [XLEN-1:0]  btb_wdata,
        input logic             pht_we,
        input logic             pht_inc,
        input logic [GHR_W-1:0] pht_waddr,
        input logic             ghr_clear
    );
        @(negedge clk);
        pc_i        = pc;
        op_i        = op;
        btb_we_i    = btb_we;
        btb_waddr_i = btb_waddr;
        btb_wdata_i = btb_wdata;
        pht_we_i    = pht_we;
        pht_inc_i   = pht_inc;
        pht_waddr_i = pht_waddr;
        ghr_clear_i = ghr_clear;
    endtask

    task automatic fetch(input logic [XLEN-1:0] pc, input logic ghr_clear);
        drive(pc, bp_pkg::OP_OTHER, 1'b0, '0, '0, 1'b0, 1'b0, '0, ghr_clear);
    endtask

    // Fetch, decode and execute of one control-flow instruction
    task automatic install(
        input logic [XLEN-1:0] pc,
        input bp_pkg::opcode_e op,
        input logic [XLEN-1:0] target
    );
        fetch(pc, 1'b0);
        drive(FILL_PC, op, 1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b0);
        drive(FILL_PC, bp_pkg::OP_OTHER, 1'b1, pc[IDX_W+1:2], target, 1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic step_counter(input logic inc, input logic [GHR_W-1:0] waddr);
        drive(FILL_PC, bp_pkg::OP_OTHER, 1'b0, '0, '0, 1'b1, inc, waddr, 1'b1);
    endtask

    initial begin
        logic [XLEN-1:0]  cur_pc;
        logic [XLEN-1:0]  pc_hist1;
        logic [XLEN-1:0]  pc_hist2;
        bp_pkg::opcode_e  r_op;
        logic             r_btb_we;
        logic [IDX_W-1:0] r_waddr;
        logic [XLEN-1:0]  r_wdata;
        logic             r_pht_we;
        logic             r_inc;
        logic [GHR_W-1:0] r_pwaddr;
        logic             r_clear;

        void'($urandom(32'h6fca_588d));
        rst_n_i     = 1'b0;
        pc_i        = '0;
        op_i        = bp_pkg::OP_OTHER;
        btb_we_i    = 1'b0;
        btb_waddr_i = '0;
        btb_wdata_i = '0;
        pht_we_i    = 1'b0;
        pht_inc_i   = 1'b0;
        pht_waddr_i = '0;
        ghr_clear_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;

        phase = 1;
        foreach (pc_pool[i]) begin
            fetch(pc_pool[i], 1'b0);
        end

        phase = 2;
        install(32'h0000_0100, bp_pkg::OP_JAL, 32'h0000_0400);
        install(32'h0000_2040, bp_pkg::OP_JALR, 32'h0000_0800);
        fetch(32'h0000_0100, 1'b0);
        fetch(32'h0000_2040, 1'b0);
        // Lookup hits here and the entry keeps its old target
        install(32'h0000_0100, bp_pkg::OP_BRANCH, 32'h0000_999c);
        fetch(32'h0000_0100, 1'b0);
        fetch(32'h0000_0180, 1'b0);

        phase = 3;
        install(BR_PC, bp_pkg::OP_BRANCH, 32'h0000_0500);
        fetch(BR_PC, 1'b0);
        fetch(32'h0000_1104, 1'b0);
        fetch(BR_PC, 1'b0);

        // History held at zero so the branch reads the counter being stepped
        // Four steps land on a different MSB if the counter wraps
        phase = 4;
        repeat (4) step_counter(1'b1, BR_PC[GHR_W+1:2]);
        fetch(BR_PC, 1'b1);
        repeat (4) step_counter(1'b0, BR_PC[GHR_W+1:2]);
        fetch(BR_PC, 1'b1);

        phase = 5;
        fetch(FILL_PC, 1'b1);
        repeat (4) begin
            fetch(32'h0000_0100, 1'b0);
            fetch(FILL_PC, 1'b0);
        end
        fetch(32'h0000_0100, 1'b1);
        fetch(32'h0000_007c, 1'b0);

        phase = 6;
        cur_pc   = FILL_PC;
        pc_hist1 = FILL_PC;
        repeat (RANDOM_CYCLES) begin
            pc_hist2 = pc_hist1;
            pc_hist1 = cur_pc;
            cur_pc   = pc_pool[$urandom % 8];
            r_op     = op_pool[$urandom % 4];
            r_btb_we = ($urandom % 3) == 0;
            // Mostly refill the slot of the instruction now at execute
            if (($urandom % 4) != 0) begin
                r_waddr = pc_hist2[IDX_W+1:2];
            end else begin
                r_waddr = IDX_W'($urandom);
            end
            r_wdata  = $urandom & 32'hffff_fffc;
            r_pht_we = $urandom % 2;
            r_inc    = $urandom % 2;
            r_pwaddr = GHR_W'($urandom);
            r_clear  = ($urandom % 16) == 0;
            drive(cur_pc, r_op, r_btb_we, r_waddr, r_wdata, r_pht_we, r_inc, r_pwaddr, r_clear);
        end
        @(negedge clk);

        if (u_chk.taken_seen == 0) begin
            other_errors++;
            $display("The random phase never produced a taken prediction");
        end
        if (u_chk.branch_hits == 0) begin
            other_errors++;
            $display("The random phase never hit a branch entry");
        end

        total_errors = u_chk.target_errors + u_chk.taken_errors + u_chk.raddr_errors
                     + other_errors;
        $display("Checks %0d, target errors %0d, taken errors %0d, raddr errors %0d, other %0d",
                 u_chk.check_count, u_chk.target_errors, u_chk.taken_errors,
                 u_chk.raddr_errors, other_errors);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIME_LIMIT);
        $display("Timeout: the run did not finish within %0d time units", TIME_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/bp_pkg.sv
src/btb_lookup_if.sv
src/btb.sv
src/gshare_pht.sv
src/predict_select.sv
src/branch_predictor.sv
tests/bp_checker.sv
tests/tb_branch_predictor.sv

/* Bender.yml */
package:
  name: branch_predictor

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/bp_pkg.sv
      - src/btb_lookup_if.sv
      - src/btb.sv
      - src/gshare_pht.sv
      - src/predict_select.sv
      - src/branch_predictor.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/bp_checker.sv
      - tests/tb_branch_predictor.sv
